// ==== rtl/chiplet_defs.svh ====
`ifndef CHIPLET_DEFS_SVH
`define CHIPLET_DEFS_SVH

`define NUM_MSGS         4
`define TX_MEM_WORDS     64
`define PKT_LENGTH_WIDTH 8
`define SWITCH_BUF_DEPTH 8
`define NODE_ID_WIDTH    4

// start address of slot i sits at byte 4*i and the two registers follow them.
`define CFG_MEM_BASE     32'h0000_1000
`define CFG_TRIG_ADDR    32'h0000_0010
`define CFG_NODE_ADDR    32'h0000_0014

`endif

// ==== rtl/chiplet_pkg.sv ====
`default_nettype none

`include "chiplet_defs.svh"

package chiplet_pkg;

    typedef logic [31:0] word_t;

    typedef logic [$clog2(`NUM_MSGS)-1:0] pkt_id_t;

    typedef logic [`NODE_ID_WIDTH-1:0] node_id_t;

    typedef logic [`PKT_LENGTH_WIDTH-1:0] pkt_len_t;

    typedef struct packed {
        logic     vc;
        pkt_id_t  id;
        node_id_t req;
    } flit_meta_t;

    typedef struct packed {
        flit_meta_t metadata;
        word_t      payload;
    } flit_t;

    // the header word carries the total flit count, header included, in its low bits.
    function automatic pkt_len_t header_num_flits(word_t header);
        return header[`PKT_LENGTH_WIDTH-1:0];
    endfunction

endpackage

`default_nettype wire

// ==== rtl/tx_ifs.sv ====
`default_nettype none

`include "chiplet_defs.svh"

interface msg_table_if;
    import chiplet_pkg::*;

    logic [`NUM_MSGS-1:0]    trigger;
    word_t [`NUM_MSGS-1:0]   start_addr;
    node_id_t                node_id;
    logic                    done;
    pkt_id_t                 done_id;

    modport tbl (
        output trigger, start_addr, node_id,
        input  done, done_id
    );

    modport fsm (
        input  trigger, start_addr, node_id,
        output done, done_id
    );
endinterface

interface mem_rd_if;
    import chiplet_pkg::*;

    logic  ren;
    word_t addr;
    word_t rdata;
    logic  stall;

    modport mem (input ren, addr, output rdata, stall);

    modport fsm (output ren, addr, input rdata, stall);
endinterface

`default_nettype wire

// ==== rtl/flit_counter.sv ====
`default_nettype none

module flit_counter #(
    parameter int NBITS = 8
) (
    input  logic             clk,
    input  logic             n_rst,
    input  logic             clear,
    input  logic             count_enable,
    input  logic [NBITS-1:0] overflow_val,
    output logic [NBITS-1:0] count_out,
    output logic             overflow_flag
);
    assign overflow_flag = (count_out == overflow_val);

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            count_out <= '0;
        end else if (clear) begin
            count_out <= '0;
        end else if (count_enable && !overflow_flag) begin
            count_out <= count_out + 1'b1;
        end
    end

    // the limit may only move while the count is cleared.
    a_no_overrun: assert property (@(posedge clk) disable iff (!n_rst)
        count_out <= overflow_val);

endmodule

`default_nettype wire

// ==== rtl/msg_table.sv ====
`default_nettype none

`include "chiplet_defs.svh"

module msg_table (
    input  logic                 clk,
    input  logic                 n_rst,
    input  logic                 cfg_wen,
    input  chiplet_pkg::word_t   cfg_addr,
    input  chiplet_pkg::word_t   cfg_wdata,
    msg_table_if.tbl             msg,
    output logic [`NUM_MSGS-1:0] msg_pending
);
    import chiplet_pkg::*;

    word_t [`NUM_MSGS-1:0] start_q;
    node_id_t              node_q;
    logic [`NUM_MSGS-1:0]  trigger_q;
    logic [`NUM_MSGS-1:0]  trig_set;
    logic [`NUM_MSGS-1:0]  trig_clr;
    logic                  tbl_wen;

    assign tbl_wen = cfg_wen && (cfg_addr < `CFG_MEM_BASE);

    assign trig_set = (tbl_wen && cfg_addr == `CFG_TRIG_ADDR) ?
                      cfg_wdata[`NUM_MSGS-1:0] : '0;
    assign trig_clr = msg.done ? (`NUM_MSGS'(1) << msg.done_id) : '0;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            start_q   <= '0;
            node_q    <= '0;
            trigger_q <= '0;
        end else begin
            for (int i = 0; i < `NUM_MSGS; i++) begin
                if (tbl_wen && cfg_addr == word_t'(4 * i)) begin
                    start_q[i] <= cfg_wdata;
                end
            end
            if (tbl_wen && cfg_addr == `CFG_NODE_ADDR) begin
                node_q <= cfg_wdata[`NODE_ID_WIDTH-1:0];
            end
            // a new trigger from software beats a completion on the same slot.
            trigger_q <= (trigger_q & ~trig_clr) | trig_set;
        end
    end

    assign msg.trigger    = trigger_q;
    assign msg.start_addr = start_q;
    assign msg.node_id    = node_q;
    assign msg_pending    = trigger_q;

    a_done_pending: assert property (@(posedge clk) disable iff (!n_rst)
        msg.done |-> trigger_q[msg.done_id]);

endmodule

`default_nettype wire

// ==== rtl/tx_mem.sv ====
`default_nettype none

`include "chiplet_defs.svh"

module tx_mem (
    input  logic               clk,
    input  logic               n_rst,
    input  logic               cfg_wen,
    input  chiplet_pkg::word_t cfg_addr,
    input  chiplet_pkg::word_t cfg_wdata,
    mem_rd_if.mem              rd
);
    import chiplet_pkg::*;

    localparam int AW = $clog2(`TX_MEM_WORDS);

    word_t          mem [`TX_MEM_WORDS];
    word_t          wr_off;
    word_t          rd_off;
    logic [AW-1:0]  wr_idx;
    logic [AW-1:0]  rd_idx;
    logic           mem_wen;

    // both ports use config space byte addresses, so the base is removed here.
    assign mem_wen = cfg_wen && (cfg_addr >= `CFG_MEM_BASE);
    assign wr_off  = cfg_addr - `CFG_MEM_BASE;
    assign rd_off  = rd.addr - `CFG_MEM_BASE;
    assign wr_idx  = wr_off[AW+1:2];
    assign rd_idx  = rd_off[AW+1:2];

    always_ff @(posedge clk) begin
        if (mem_wen) begin
            mem[wr_idx] <= cfg_wdata;
        end
    end

    assign rd.rdata = mem[rd_idx];

    // there is a single port into the array, so software writes win.
    assign rd.stall = rd.ren && mem_wen;

    a_rd_in_range: assert property (@(posedge clk) disable iff (!n_rst)
        rd.ren |-> (rd.addr >= `CFG_MEM_BASE) &&
                   (rd.addr < `CFG_MEM_BASE + 4 * `TX_MEM_WORDS));

endmodule

`default_nettype wire

// ==== rtl/tx_fsm.sv ====
`default_nettype none

`include "chiplet_defs.svh"

module tx_fsm (
    input  logic               clk,
    input  logic               n_rst,
    msg_table_if.fsm           msg,
    mem_rd_if.fsm              rd,
    output logic               flit_valid,
    input  logic               flit_ready,
    output chiplet_pkg::flit_t flit_data,
    input  logic               credit_return
);
    import chiplet_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        START,
        SEND
    } state_e;

    localparam pkt_len_t WINDOW = pkt_len_t'(3 * `SWITCH_BUF_DEPTH / 4);

    state_e   state, next_state;
    pkt_id_t  cur_id, next_id;
    pkt_len_t pkt_len, next_len;
    pkt_len_t sent;
    word_t    base_addr;
    word_t    held_payload;
    logic     len_clear;
    logic     len_done;
    logic     win_full;
    logic     accept;
    logic     holding;

    assign len_clear = (state == IDLE);
    assign accept    = flit_valid && flit_ready;

    flit_counter #(
        .NBITS(`PKT_LENGTH_WIDTH)
    ) u_len_cnt (
        .clk          (clk),
        .n_rst        (n_rst),
        .clear        (len_clear),
        .count_enable (accept),
        .overflow_val (pkt_len),
        .count_out    (sent),
        .overflow_flag(len_done)
    );

    flit_counter #(
        .NBITS(`PKT_LENGTH_WIDTH)
    ) u_win_cnt (
        .clk          (clk),
        .n_rst        (n_rst),
        .clear        (credit_return),
        .count_enable (accept),
        .overflow_val (WINDOW),
        .count_out    (),
        .overflow_flag(win_full)
    );

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state   <= IDLE;
            cur_id  <= '0;
            pkt_len <= '0;
            holding <= 1'b0;
        end else begin
            state   <= next_state;
            cur_id  <= next_id;
            pkt_len <= next_len;
            if (accept) begin
                holding <= 1'b0;
            end else if (flit_valid) begin
                holding <= 1'b1;
            end
        end
    end

    // a stalled flit keeps its payload here so a later memory stall cannot disturb it.
    always_ff @(posedge clk) begin
        if (flit_valid && !holding) begin
            held_payload <= rd.rdata;
        end
    end

    always_comb begin
        next_state = state;
        next_id    = cur_id;
        next_len   = pkt_len;
        msg.done   = 1'b0;
        case (state)
            IDLE: begin
                if (|msg.trigger) begin
                    next_state = START;
                    // highest set slot wins.
                    for (int i = 0; i < `NUM_MSGS; i++) begin
                        if (msg.trigger[i]) begin
                            next_id = pkt_id_t'(i);
                        end
                    end
                end
            end
            START: begin
                if (!rd.stall) begin
                    next_len   = header_num_flits(rd.rdata);
                    next_state = SEND;
                end
            end
            SEND: begin
                if (len_done) begin
                    msg.done   = 1'b1;
                    next_state = IDLE;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    assign msg.done_id = cur_id;

    // the sent count is zero in START, so the same address points at the header.
    assign base_addr = msg.start_addr[cur_id];
    assign rd.addr   = base_addr + (word_t'(sent) << 2);
    assign rd.ren    = (state == START) || (state == SEND && !len_done && !holding);

    assign flit_valid = holding || (state == SEND && !len_done && !win_full && !rd.stall);

    assign flit_data.metadata.vc  = 1'b0;
    assign flit_data.metadata.id  = cur_id;
    assign flit_data.metadata.req = msg.node_id;
    assign flit_data.payload      = holding ? held_payload : rd.rdata;

    a_flit_stable: assert property (@(posedge clk) disable iff (!n_rst)
        flit_valid && !flit_ready |=> flit_valid && $stable(flit_data));

endmodule

`default_nettype wire

// ==== rtl/chiplet_tx_top.sv ====
`default_nettype none

`include "chiplet_defs.svh"

module chiplet_tx_top (
    input  logic                 clk,
    input  logic                 n_rst,
    input  logic                 cfg_wen,
    input  logic [31:0]          cfg_addr,
    input  logic [31:0]          cfg_wdata,
    output logic                 flit_valid,
    input  logic                 flit_ready,
    output chiplet_pkg::flit_t   flit_data,
    input  logic                 credit_return,
    output logic [`NUM_MSGS-1:0] msg_pending
);
    msg_table_if u_msg_if ();
    mem_rd_if    u_rd_if ();

    msg_table u_msg_table (
        .clk        (clk),
        .n_rst      (n_rst),
        .cfg_wen    (cfg_wen),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .msg        (u_msg_if.tbl),
        .msg_pending(msg_pending)
    );

    tx_mem u_tx_mem (
        .clk      (clk),
        .n_rst    (n_rst),
        .cfg_wen  (cfg_wen),
        .cfg_addr (cfg_addr),
        .cfg_wdata(cfg_wdata),
        .rd       (u_rd_if.mem)
    );

    tx_fsm u_tx_fsm (
        .clk          (clk),
        .n_rst        (n_rst),
        .msg          (u_msg_if.fsm),
        .rd           (u_rd_if.fsm),
        .flit_valid   (flit_valid),
        .flit_ready   (flit_ready),
        .flit_data    (flit_data),
        .credit_return(credit_return)
    );

endmodule

`default_nettype wire

// ==== sim/tb_chiplet_tx.sv ====
`default_nettype none

`include "chiplet_defs.svh"

module tb_chiplet_tx;
    timeunit 1ns;
    timeprecision 1ps;

    import chiplet_pkg::*;

    localparam word_t MEM_BASE = `CFG_MEM_BASE;
    localparam int    WINDOW   = 3 * `SWITCH_BUF_DEPTH / 4;

    logic                 clk;
    logic                 n_rst;
    logic                 cfg_wen;
    logic [31:0]          cfg_addr;
    logic [31:0]          cfg_wdata;
    logic                 flit_valid;
    logic                 flit_ready;
    flit_t                flit_data;
    logic                 credit_return;
    logic [`NUM_MSGS-1:0] msg_pending;

    // shadow copy of everything software wrote.
    word_t    mem_model [`TX_MEM_WORDS];
    word_t    start_model [`NUM_MSGS];
    node_id_t node_model;
    flit_t    exp_q [$];

    int errors       = 0;
    int err_mark     = 0;
    int tests_run    = 0;
    int tests_failed = 0;
    int accepted_cnt = 0;
    int win_model    = 0;
    bit ready_rand   = 1'b0;
    bit credit_auto  = 1'b1;
    bit rst_seen     = 1'b0;

    chiplet_tx_top u_chiplet_tx_top (
        .clk          (clk),
        .n_rst        (n_rst),
        .cfg_wen      (cfg_wen),
        .cfg_addr     (cfg_addr),
        .cfg_wdata    (cfg_wdata),
        .flit_valid   (flit_valid),
        .flit_ready   (flit_ready),
        .flit_data    (flit_data),
        .credit_return(credit_return),
        .msg_pending  (msg_pending)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        repeat (20000) @(posedge clk);
        $display("watchdog expired before the tests finished");
        $display("Some tests failed");
        $finish;
    end

    // every accepted flit must be the next one software laid out in memory.
    always @(posedge clk) begin
        if (n_rst && flit_valid && flit_ready) begin
            accepted_cnt <= accepted_cnt + 1;
            assert (exp_q.size() > 0) else begin
                $display("[ERROR] %0t: unexpected flit %h", $time, flit_data);
                errors++;
            end
            if (exp_q.size() > 0) begin
                assert (flit_data == exp_q[0]) else begin
                    $display("[ERROR] %0t: flit %h, expected %h", $time, flit_data, exp_q[0]);
                    errors++;
                end
                void'(exp_q.pop_front());
            end
        end
    end

    always @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            win_model <= 0;
        end else if (credit_return) begin
            win_model <= 0;
        end else if (flit_valid && flit_ready) begin
            win_model <= win_model + 1;
        end
    end

    // the flops are only known to be reset once a clock edge has seen n_rst low.
    always @(posedge clk) begin
        if (!n_rst) begin
            rst_seen <= 1'b1;
        end
    end

    a_reset_quiet: assert property (@(posedge clk)
        !n_rst && rst_seen |-> !flit_valid && msg_pending == '0)
        else begin
            $display("[ERROR] %0t: activity during reset", $time);
            errors++;
        end

    a_first_edge: assert property (@(posedge clk)
        $rose(n_rst) |-> !flit_valid && msg_pending == '0)
        else begin
            $display("[ERROR] %0t: activity on the first edge after reset", $time);
            errors++;
        end

    a_hold_stable: assert property (@(posedge clk) disable iff (!n_rst)
        flit_valid && !flit_ready |=> flit_valid && $stable(flit_data))
        else begin
            $display("[ERROR] %0t: stalled flit changed or was dropped", $time);
            errors++;
        end

    a_window: assert property (@(posedge clk) disable iff (!n_rst)
        flit_valid |-> win_model < WINDOW)
        else begin
            $display("[ERROR] %0t: flit offered with the send window full", $time);
            errors++;
        end

    task automatic tick();
        @(posedge clk);
        flit_ready    <= ready_rand ? ($urandom % 2 == 1) : 1'b1;
        credit_return <= credit_auto && ($urandom % 4 == 0);
    endtask

    task automatic cfg_write(input word_t addr, input word_t data);
        tick();
        cfg_wen   <= 1'b1;
        cfg_addr  <= addr;
        cfg_wdata <= data;
        if (addr >= MEM_BASE) begin
            mem_model[int'((addr - MEM_BASE) >> 2)] = data;
        end else if (addr == `CFG_NODE_ADDR) begin
            node_model = data[`NODE_ID_WIDTH-1:0];
        end else if (addr < 4 * `NUM_MSGS) begin
            start_model[int'(addr >> 2)] = data;
        end
    endtask

    task automatic cfg_idle();
        tick();
        cfg_wen <= 1'b0;
    endtask

    task automatic trigger(input logic [`NUM_MSGS-1:0] mask);
        cfg_write(`CFG_TRIG_ADDR, word_t'(mask));
        cfg_idle();
        tick();
    endtask

    task automatic pulse_credit();
        tick();
        credit_return <= 1'b1;
        tick();
        credit_return <= 1'b0;
    endtask

    // the header goes first and carries the flit count in its low byte.
    task automatic load_packet(input int slot, input int first_word, input int len);
        word_t data;
        for (int k = 0; k < len; k++) begin
            data = (k == 0) ? (($urandom & 32'hffff_ff00) | word_t'(len)) : $urandom;
            cfg_write(MEM_BASE + word_t'(4 * (first_word + k)), data);
        end
        cfg_write(word_t'(4 * slot), MEM_BASE + word_t'(4 * first_word));
        cfg_idle();
    endtask

    task automatic push_expected(input int slot);
        int    idx;
        int    len;
        flit_t f;
        idx = int'((start_model[slot] - MEM_BASE) >> 2);
        len = int'(mem_model[idx][`PKT_LENGTH_WIDTH-1:0]);
        for (int k = 0; k < len; k++) begin
            f.metadata.vc  = 1'b0;
            f.metadata.id  = pkt_id_t'(slot);
            f.metadata.req = node_model;
            f.payload      = mem_model[idx + k];
            exp_q.push_back(f);
        end
    endtask

    task automatic wait_slot_done(input int slot, input int limit);
        int n;
        n = 0;
        while (msg_pending[slot] && n < limit) begin
            tick();
            n++;
        end
        if (msg_pending[slot]) begin
            $display("timeout: slot %0d did not finish within %0d cycles", slot, limit);
            errors++;
        end
    endtask

    task automatic wait_accepted(input int target, input int limit);
        int n;
        n = 0;
        while (accepted_cnt < target && n < limit) begin
            tick();
            n++;
        end
        if (accepted_cnt < target) begin
            $display("timeout: only %0d of %0d flits accepted", accepted_cnt, target);
            errors++;
        end
    endtask

    task automatic expect_true(input bit cond, input string what);
        assert (cond) else begin
            $display("[ERROR] %0t: %s", $time, what);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == err_mark) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAILED with %0d errors", tests_run, name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    initial begin
        int base;
        base          = $urandom(14);
        n_rst         = 1'b0;
        cfg_wen       = 1'b0;
        cfg_addr      = '0;
        cfg_wdata     = '0;
        flit_ready    = 1'b0;
        credit_return = 1'b0;

        tick();
        tick();
        n_rst <= 1'b1;
        tick();
        tick();
        finish_test("reset");

        cfg_write(`CFG_NODE_ADDR, 32'h5);
        load_packet(1, 0, 4);
        push_expected(1);
        base = accepted_cnt;
        trigger(4'b0010);
        wait_slot_done(1, 200);
        expect_true(accepted_cnt - base == 4 && exp_q.size() == 0, "slot 1 ended early or late");
        finish_test("single packet");

        load_packet(2, 4, 5);
        push_expected(2);
        base       = accepted_cnt;
        ready_rand = 1'b1;
        trigger(4'b0100);
        wait_slot_done(2, 300);
        ready_rand = 1'b0;
        expect_true(accepted_cnt - base == 5 && exp_q.size() == 0, "slot 2 flit count wrong");
        finish_test("back-pressure");

        credit_auto = 1'b0;
        pulse_credit();
        load_packet(0, 9, 10);
        push_expected(0);
        base = accepted_cnt;
        trigger(4'b0001);
        wait_accepted(base + WINDOW, 200);
        repeat (8) tick();
        expect_true(accepted_cnt - base == WINDOW && msg_pending[0], "window did not hold");
        pulse_credit();
        wait_slot_done(0, 200);
        expect_true(accepted_cnt - base == 10 && exp_q.size() == 0, "slot 0 flit count wrong");
        credit_auto = 1'b1;
        finish_test("send window");

        cfg_write(`CFG_NODE_ADDR, 32'hc);
        load_packet(0, 19, 3);
        load_packet(2, 22, 4);
        load_packet(3, 26, 5);
        push_expected(3);
        push_expected(2);
        push_expected(0);
        base = accepted_cnt;
        trigger(4'b1101);
        expect_true(msg_pending == 4'b1101, "trigger bits not all pending");
        wait_slot_done(3, 200);
        expect_true(accepted_cnt - base == 5 && msg_pending[2] && msg_pending[0],
                    "slot 3 did not end first");
        wait_slot_done(2, 200);
        expect_true(accepted_cnt - base == 9 && msg_pending[0], "slot 2 did not end second");
        wait_slot_done(0, 200);
        expect_true(accepted_cnt - base == 12 && exp_q.size() == 0, "slot 0 did not end last");
        finish_test("arbitration");

        load_packet(3, 31, 8);
        push_expected(3);
        base       = accepted_cnt;
        ready_rand = 1'b1;
        cfg_write(`CFG_TRIG_ADDR, 32'h8);
        // writes to the unused top of memory collide with the packet reads.
        for (int i = 0; i < 16; i++) begin
            cfg_write(MEM_BASE + word_t'(4 * (48 + i)), $urandom);
            cfg_idle();
        end
        wait_slot_done(3, 400);
        ready_rand = 1'b0;
        expect_true(accepted_cnt - base == 8 && exp_q.size() == 0, "slot 3 flit count wrong");
        finish_test("collision");

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+rtl
rtl/chiplet_pkg.sv
rtl/tx_ifs.sv
rtl/flit_counter.sv
rtl/msg_table.sv
rtl/tx_mem.sv
rtl/tx_fsm.sv
rtl/chiplet_tx_top.sv
sim/tb_chiplet_tx.sv

// ==== Bender.yml ====
package:
  name: chiplet_tx

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/chiplet_pkg.sv
      - rtl/tx_ifs.sv
      - rtl/flit_counter.sv
      - rtl/msg_table.sv
      - rtl/tx_mem.sv
      - rtl/tx_fsm.sv
      - rtl/chiplet_tx_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - sim/tb_chiplet_tx.sv
